//--- logic/core_pkg.sv
package core_pkg;

	// ####################
	// widths with a meaning

	// data and instruction values
	typedef logic [31:0] word;

	// word address with the byte offset bits 1:0 implied zero
	typedef logic [29:0] ptr;

	typedef logic [3:0] reg_num;    // r0 to r15 where r15 is the pc
	typedef logic [3:0] cond_code;  // eq, ne, cs ... al, nv

	// signed word offset held in bits 23:0 of b and bl
	typedef logic [23:0] branch_off;

	// ####################
	// instruction classes

	// The decoder checks these in a fixed order, so the multiply pattern
	// is tested before the broader data processing one and the media
	// space of 011 with bit 4 set comes out as undefined
	typedef enum logic [2:0] {
		class_data_proc,     // 00x for alu ops, psr transfers and bx
		class_multiply,      // 000000 with 1001 in bits 7:4
		class_mem_single,    // 01x for ldr and str
		class_mem_multiple,  // 100 for ldm and stm
		class_branch,        // 101 for b and bl
		class_coproc_swi,    // 11x for cdp, mcr, mrc, ldc, stc and swi
		class_undefined      // 011 with bit 4 set
	} insn_class;

endpackage

//--- logic/core_fetch.sv
`timescale 1ns/1ps

module core_fetch
#(
	parameter int PREFETCH_ORDER = 2
)
(
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    branch,
	input  core_pkg::ptr            branch_target,

	input  logic [PREFETCH_ORDER:0] count,

	output logic                    insn_start,
	output core_pkg::ptr            insn_addr,
	input  logic                    insn_ready,
	input  core_pkg::word           insn_data_rd,

	output logic                    push,
	output core_pkg::ptr            push_pc,
	output core_pkg::word           push_insn
);

	typedef logic [PREFETCH_ORDER:0] level;

	localparam level DEPTH = level'(1) << PREFETCH_ORDER;

	core_pkg::ptr pc;
	logic outstanding, stale, can_issue;

	// a read in flight holds one queue slot, so nothing is issued while one is out
	assign can_issue = !outstanding && !branch && count < DEPTH;

	// ####################
	// read issue

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			insn_start <= 0;
			outstanding <= 0;
			stale <= 0;
		end else begin
			insn_start <= can_issue; // one cycle only since outstanding blocks the next one

			if (can_issue) begin
				outstanding <= 1;
				pc <= pc + 30'd1;
			end else if (insn_ready)
				outstanding <= 0;

			if (insn_ready)
				stale <= 0;

			if (branch) begin
				pc <= branch_target;
				stale <= outstanding && !insn_ready; // its word belongs to the old path
			end
		end
	end

	// the address stays put until the read returns
	always_ff @(posedge clk)
		if (can_issue)
			insn_addr <= pc;

	// ####################
	// completion

	assign push = insn_ready && !stale;
	assign push_pc = insn_addr;
	assign push_insn = insn_data_rd;

endmodule

//--- logic/core_prefetch.sv
`timescale 1ns/1ps

module core_prefetch
#(
	parameter int PREFETCH_ORDER = 2
)
(
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    branch,

	input  logic                    push,
	input  core_pkg::ptr            push_pc,
	input  core_pkg::word           push_insn,

	input  logic                    pop,
	output logic [PREFETCH_ORDER:0] count,
	output logic                    head_valid,
	output core_pkg::ptr            head_pc,
	output core_pkg::word           head_insn
);

	localparam int DEPTH = 1 << PREFETCH_ORDER;

	// the top bit tells a full queue from an empty one
	typedef logic [PREFETCH_ORDER:0] qptr;

	qptr rd_ptr, wr_ptr;
	logic [PREFETCH_ORDER - 1:0] rd_idx, wr_idx;

	core_pkg::ptr pc_q[DEPTH];
	core_pkg::word insn_q[DEPTH];

	assign rd_idx = rd_ptr[PREFETCH_ORDER - 1:0];
	assign wr_idx = wr_ptr[PREFETCH_ORDER - 1:0];

	assign count = wr_ptr - rd_ptr;
	assign head_valid = count != '0;

	assign head_pc = pc_q[rd_idx];
	assign head_insn = insn_q[rd_idx];

	// ####################
	// pointers

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else if (branch)
			rd_ptr <= wr_ptr; // drop everything including an incoming push
		else begin
			if (push)
				wr_ptr <= wr_ptr + qptr'(1);

			if (pop)
				rd_ptr <= rd_ptr + qptr'(1);
		end
	end

	// ####################
	// storage

	always_ff @(posedge clk)
		if (push) begin
			pc_q[wr_idx] <= push_pc;
			insn_q[wr_idx] <= push_insn;
		end

endmodule

//--- logic/core_decode.sv
`timescale 1ns/1ps

module core_decode
(
	input  logic                clk,
	input  logic                rst,

	input  logic                branch,
	input  logic                stall,

	input  logic                head_valid,
	input  core_pkg::ptr        head_pc,
	input  core_pkg::word       head_insn,
	output logic                pop,

	output logic                dec_valid,
	output core_pkg::ptr        dec_pc,
	output core_pkg::word       dec_insn,
	output core_pkg::insn_class dec_class,
	output core_pkg::cond_code  dec_cond,
	output core_pkg::reg_num    dec_rn,
	output core_pkg::reg_num    dec_rd,
	output core_pkg::ptr        dec_target
);

	core_pkg::insn_class head_class;
	core_pkg::branch_off offset;
	core_pkg::ptr head_target;
	logic advance;

	// the output register is free, or its content is being taken this cycle
	assign advance = !dec_valid || !stall;
	assign pop = head_valid && advance && !branch;

	// pc reads two words ahead of the branch itself
	assign offset = head_insn[23:0];
	assign head_target = head_pc + 30'd2 + {{6{offset[23]}}, offset};

	always_comb begin
		if (head_insn[27:24] == 4'b1111)
			head_class = core_pkg::class_coproc_swi; // swi
		else if (head_insn[27:22] == 6'b000000 && head_insn[7:4] == 4'b1001)
			head_class = core_pkg::class_multiply;
		else if (head_insn[27:26] == 2'b00)
			head_class = core_pkg::class_data_proc;
		else if (head_insn[27:25] == 3'b011 && head_insn[4])
			head_class = core_pkg::class_undefined;
		else if (head_insn[27:26] == 2'b01)
			head_class = core_pkg::class_mem_single;
		else if (head_insn[27:25] == 3'b100)
			head_class = core_pkg::class_mem_multiple;
		else if (head_insn[27:25] == 3'b101)
			head_class = core_pkg::class_branch;
		else
			head_class = core_pkg::class_coproc_swi; // cdp, mcr, mrc, ldc, stc
	end

	// ####################
	// output register

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 0;
		else if (branch)
			dec_valid <= 0;
		else if (advance)
			dec_valid <= pop;
	end

	always_ff @(posedge clk)
		if (pop) begin
			dec_pc <= head_pc;
			dec_insn <= head_insn;
			dec_class <= head_class;
			dec_target <= head_target;
		end

	// fields come straight from the held word, so they hold with it
	assign dec_cond = dec_insn[31:28];
	assign dec_rn = dec_insn[19:16];
	assign dec_rd = dec_insn[15:12];

endmodule

//--- logic/core_bus_arb.sv
`timescale 1ns/1ps

module core_bus_arb
(
	input  logic          clk,
	input  logic          rst,

	input  logic          insn_start,
	input  core_pkg::ptr  insn_addr,
	output logic          insn_ready,
	output core_pkg::word insn_data_rd,

	input  logic          data_start,
	input  logic          data_write,
	input  core_pkg::ptr  data_addr,
	input  core_pkg::word data_data_wr,
	output logic          data_ready,
	output core_pkg::word data_data_rd,

	output core_pkg::ptr  bus_addr,
	output logic          bus_start,
	output logic          bus_write,
	output core_pkg::word bus_data_wr,
	input  logic          bus_ready,
	input  core_pkg::word bus_data_rd
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_insn,
		arb_data
	} arb_state;

	arb_state state;
	logic pend_insn, pend_data, req_insn, req_data, grant_insn, grant_data;

	// both requesters hold their address until they see ready
	assign req_insn = insn_start || pend_insn;
	assign req_data = data_start || pend_data;

	assign grant_data = state == arb_idle && req_data;
	assign grant_insn = state == arb_idle && req_insn && !req_data;

	assign bus_start = grant_data || grant_insn;
	assign bus_addr = grant_data ? data_addr : insn_addr;
	assign bus_write = grant_data && data_write;
	assign bus_data_wr = data_data_wr;

	// completions go back only to whoever owns the bus
	assign insn_ready = bus_ready && state == arb_insn;
	assign data_ready = bus_ready && state == arb_data;
	assign insn_data_rd = bus_data_rd;
	assign data_data_rd = bus_data_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= arb_idle;
			pend_insn <= 0;
			pend_data <= 0;
		end else begin
			unique case (state)
				arb_idle:
					if (grant_data)
						state <= arb_data;
					else if (grant_insn)
						state <= arb_insn;

				arb_insn, arb_data:
					if (bus_ready)
						state <= arb_idle;

				default:
					state <= arb_idle;
			endcase

			pend_insn <= req_insn && !grant_insn;
			pend_data <= req_data && !grant_data;
		end
	end

endmodule

//--- logic/arm810.sv
`timescale 1ns/1ps

module arm810
#(
	parameter int PREFETCH_ORDER = 2
)
(
	input  logic                clk,
	input  logic                rst,

	input  logic                branch,
	input  core_pkg::ptr        branch_target,
	input  logic                stall,

	output core_pkg::ptr        bus_addr,
	output logic                bus_start,
	output logic                bus_write,
	output core_pkg::word       bus_data_wr,
	input  logic                bus_ready,
	input  core_pkg::word       bus_data_rd,

	input  core_pkg::ptr        data_addr,
	input  logic                data_start,
	input  logic                data_write,
	input  core_pkg::word       data_data_wr,
	output logic                data_ready,
	output core_pkg::word       data_data_rd,

	output logic                dec_valid,
	output core_pkg::ptr        dec_pc,
	output core_pkg::word       dec_insn,
	output core_pkg::insn_class dec_class,
	output core_pkg::cond_code  dec_cond,
	output core_pkg::reg_num    dec_rn,
	output core_pkg::reg_num    dec_rd,
	output core_pkg::ptr        dec_target
);

	// ####################
	// fetch side

	core_pkg::ptr insn_addr, push_pc, head_pc;
	core_pkg::word insn_data_rd, push_insn, head_insn;
	logic insn_start, insn_ready, push, pop, head_valid;
	logic [PREFETCH_ORDER:0] count;

	core_fetch #(.PREFETCH_ORDER(PREFETCH_ORDER)) fetch
	(
		.*
	);

	core_prefetch #(.PREFETCH_ORDER(PREFETCH_ORDER)) prefetch
	(
		.*
	);

	core_decode decode
	(
		.*
	);

	// ####################
	// memory side

	core_bus_arb arb
	(
		.*
	);

endmodule

//--- test/arm810_mem.sv
`timescale 1ns/1ps

module arm810_mem
#(
	parameter int SEED = 69
)
(
	input  logic          clk,
	input  logic          rst,
	input  core_pkg::ptr  bus_addr,
	input  logic          bus_start,
	input  logic          bus_write,
	input  core_pkg::word bus_data_wr,
	output logic          bus_ready,
	output core_pkg::word bus_data_rd,
	output int            overlaps
);

	core_pkg::word prog[512];     // program region at word addresses 0 to 511
	core_pkg::word data_mem[64];  // data region selected by address bit 29

	core_pkg::ptr addr_q;
	core_pkg::word wdata_q;
	logic write_q, busy;
	int left, seed;

	function automatic core_pkg::word class_word(logic [2:0] k);
		case (k)
			3'd0: return 32'he081_0002; // add
			3'd1: return 32'he000_0291; // mul
			3'd2: return 32'he591_0000; // ldr
			3'd3: return 32'he600_0010; // undefined space
			3'd4: return 32'he8bd_000f; // ldm
			3'd5: return 32'hea00_0010; // b
			3'd6: return 32'hef00_0011; // swi
			default: return 32'hee01_0f10; // mcr
		endcase
	endfunction

	// the class order shifts with the address and the cond and register fields carry it too
	initial begin
		seed = SEED;
		for (int i = 0; i < 512; i++) begin
			prog[i] = class_word(3'(i) ^ 3'(i >> 3));
			prog[i][31:28] = 4'(i >> 5);
			prog[i][19:8] = 12'(i) ^ 12'h5a3;
		end
		for (int i = 0; i < 64; i++)
			data_mem[i] = 32'hd000_0000 ^ (32'(i) * 32'h0103_0507);
	end

	always @(posedge clk) begin
		bus_ready <= 0;
		if (rst) begin
			busy <= 0;
			overlaps <= 0;
		end else if (bus_start) begin
			assert (!busy) else begin
				$display("%0t: bus_start arrived while a transaction was still outstanding", $time);
				overlaps <= overlaps + 1;
			end
			busy <= 1;
			addr_q <= bus_addr;
			write_q <= bus_write;
			wdata_q <= bus_data_wr;
			left <= 1 + int'($unsigned($random(seed)) % 3); // 1 to 3 cycles
		end else if (busy) begin
			if (left == 1) begin
				bus_ready <= 1;
				busy <= 0;
				if (addr_q[29]) begin
					if (write_q)
						data_mem[addr_q[5:0]] = wdata_q;
					bus_data_rd <= data_mem[addr_q[5:0]];
				end else
					bus_data_rd <= prog[addr_q[8:0]];
			end else
				left <= left - 1;
		end
	end

endmodule

//--- test/arm810_tb.sv
`timescale 1ns/1ps

module arm810_tb;

	localparam int TEST_LEN = 50; // decoded words or data transfers per test
	localparam int TESTS = 5;
	localparam int LIMIT = TESTS * TEST_LEN * 8 * 2; // 8 cycles is the slowest fetch round trip

	logic clk, rst, branch, stall, data_start, data_write, data_ready;
	logic bus_start, bus_write, bus_ready, dec_valid, data_busy, held;
	core_pkg::ptr branch_target, data_addr, bus_addr, dec_pc, dec_target, exp_pc;
	core_pkg::word data_data_wr, data_data_rd, bus_data_wr, bus_data_rd, dec_insn;
	core_pkg::insn_class dec_class;
	core_pkg::cond_code dec_cond;
	core_pkg::reg_num dec_rn, dec_rd;
	core_pkg::word shadow[64];
	logic [107:0] dec_bundle, snap;
	int seed, errors, checks, overlaps, cycles, decoded, failed_tests, errors_before;

	arm810 #(.PREFETCH_ORDER(2)) dut0 (.*);
	arm810_mem mem0 (.*);

	assign dec_bundle = {dec_valid, dec_pc, dec_insn, dec_class, dec_cond, dec_rn, dec_rd,
		dec_target};

	initial clk = 0;
	always #50 clk = ~clk;

	task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic core_pkg::insn_class ref_decode(input core_pkg::ptr pc,
		input core_pkg::word w, output core_pkg::cond_code cond, output core_pkg::reg_num rn,
		output core_pkg::reg_num rd, output core_pkg::ptr target);
		cond = w[31:28];
		rn = w[19:16];
		rd = w[15:12];
		target = pc + 30'd2 + 30'($signed(w[23:0]));
		if (w[27:24] == 4'b1111)
			return core_pkg::class_coproc_swi;
		if (w[27:22] == 6'd0 && w[7:4] == 4'b1001)
			return core_pkg::class_multiply;
		case (w[27:25])
			3'b000, 3'b001: return core_pkg::class_data_proc;
			3'b010: return core_pkg::class_mem_single;
			3'b011: return w[4] ? core_pkg::class_undefined : core_pkg::class_mem_single;
			3'b100: return core_pkg::class_mem_multiple;
			3'b101: return core_pkg::class_branch;
			default: return core_pkg::class_coproc_swi;
		endcase
	endfunction

	// ####################
	// checking

	always @(posedge clk) begin : compare
		core_pkg::insn_class cls;
		core_pkg::cond_code cond;
		core_pkg::reg_num rn, rd;
		core_pkg::ptr target;
		core_pkg::word w;
		if (rst) begin
			exp_pc = '0;
			held = 0;
		end else begin
			if (held) begin
				checks++;
				assert (dec_bundle === snap) else begin
					$display("FAIL %0t dec outputs under stall: got %h, expected %h", $time,
						dec_bundle, snap);
					errors++;
				end
			end
			if (dec_valid && !stall) begin
				w = mem0.prog[exp_pc[8:0]];
				cls = ref_decode(exp_pc, w, cond, rn, rd, target);
				expect_eq("dec_pc", 32'(dec_pc), 32'(exp_pc));
				expect_eq("dec_insn", dec_insn, w);
				expect_eq("dec_class", 32'(dec_class), 32'(cls));
				expect_eq("dec_cond", 32'(dec_cond), 32'(cond));
				expect_eq("dec_rn", 32'(dec_rn), 32'(rn));
				expect_eq("dec_rd", 32'(dec_rd), 32'(rd));
				expect_eq("dec_target", 32'(dec_target), 32'(target));
				exp_pc = exp_pc + 30'd1;
				decoded++;
			end
			if (branch)
				exp_pc = branch_target; // the next decoded word starts the new path
			held = dec_valid && stall && !branch;
			snap = dec_bundle;
		end
	end

	always @(posedge clk) begin : data_check
		if (!rst && data_ready) begin
			checks++;
			assert (data_busy) else begin
				$display("data_ready pulsed at %0t with no data request waiting", $time);
				errors++;
			end
			if (data_write)
				shadow[data_addr[5:0]] = data_data_wr;
			else
				expect_eq("data_data_rd", data_data_rd, shadow[data_addr[5:0]]);
			data_busy = 0;
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ####################
	// stimulus

	task automatic wait_decoded(int n);
		int target;
		target = decoded + n;
		while (decoded < target)
			@(negedge clk);
	endtask

	task automatic transfer_data(logic write);
		@(negedge clk);
		data_addr = {1'b1, 23'd0, 6'($unsigned($random(seed)))};
		data_write = write;
		data_data_wr = $random(seed);
		data_start = 1;
		data_busy = 1;
		@(negedge clk);
		data_start = 0;
		while (data_busy)
			@(negedge clk);
	endtask

	task automatic end_test(string name);
		int found;
		found = errors + overlaps - errors_before;
		if (found != 0)
			failed_tests++;
		$display("test %s: %s, %0d errors", name, found == 0 ? "passed" : "failed", found);
		errors_before = errors + overlaps;
	endtask

	initial begin
		int n;
		seed = 69;
		rst = 1;
		branch = 0;
		branch_target = '0;
		stall = 0;
		data_start = 0;
		data_write = 0;
		data_addr = '0;
		data_data_wr = '0;
		data_busy = 0;
		errors = 0;
		checks = 0;
		cycles = 0;
		decoded = 0;
		failed_tests = 0;
		errors_before = 0;
		for (int i = 0; i < 64; i++)
			shadow[i] = 32'hd000_0000 ^ (32'(i) * 32'h0103_0507);
		repeat (5) @(negedge clk);
		rst = 0;

		wait_decoded(TEST_LEN);
		end_test("straight-line stream");

		n = decoded + TEST_LEN;
		while (decoded < n) begin
			@(negedge clk);
			stall = ($random(seed) & 1) != 0;
		end
		@(negedge clk);
		stall = 0;
		end_test("stall");

		for (int k = 0; k < 5; k++) begin
			repeat (1 + $unsigned($random(seed)) % 6) @(negedge clk); // often mid fetch
			branch = 1;
			branch_target = 30'd64 + 30'(k * 32) + 30'($unsigned($random(seed)) % 16);
			@(negedge clk);
			branch = 0;
			wait_decoded(TEST_LEN / 5);
		end
		end_test("branch");

		stall = 1; // the queue fills and fetch goes quiet
		for (int k = 0; k < TEST_LEN; k++)
			transfer_data(($random(seed) & 1) != 0);
		stall = 0;
		end_test("data port");

		n = decoded + TEST_LEN;
		while (decoded < n)
			transfer_data(($random(seed) & 1) != 0);
		end_test("contention and latency");

		repeat (2) @(negedge clk);
		$display("tests %0d, failed %0d, checks %0d, errors %0d", TESTS, failed_tests, checks,
			errors + overlaps);
		if (errors + overlaps == 0 && failed_tests == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- src.f
logic/core_pkg.sv
logic/core_fetch.sv
logic/core_prefetch.sv
logic/core_decode.sv
logic/core_bus_arb.sv
logic/arm810.sv
test/arm810_mem.sv
test/arm810_tb.sv

//--- Makefile
TOP = arm810_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f src.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir $(LOG)
